// File: mem_pkg.sv
package mem_pkg;

    // Memory geometry.
    localparam int unsigned MEM_BYTES  = 256;                // Total bytes in the array.
    localparam int unsigned MEM_ADDR_W = $clog2(MEM_BYTES);  // Byte index width.
    localparam int unsigned MEM_LANES  = 4;                  // Bytes per 32-bit word.

    // Store width as carried on the store channel.
    // Code 2'b11 is undefined and writes no bytes.
    typedef enum logic [1:0] {
        BYTE      = 2'b00,  // One byte, lane 0.
        HALF_WORD = 2'b01,  // Two bytes, lanes 0 and 1.
        WORD      = 2'b10   // All four lanes.
    } store_width_e;

    // Read request, shared by the load and fetch channels.
    typedef struct packed {
        logic        request;  // One-cycle strobe.
        logic [31:0] address;  // Byte address, upper bits ignored.
    } rd_req_t;

    // Read response, shared by the load and fetch channels.
    typedef struct packed {
        logic        valid;  // High for one cycle per request.
        logic [31:0] data;   // Little-endian word.
    } rd_rsp_t;

    // Store request.
    typedef struct packed {
        logic         request;  // One-cycle strobe.
        store_width_e width;    // Number of bytes written.
        logic [31:0]  address;  // Start byte, any alignment.
        logic [31:0]  data;     // Low bytes are written first.
    } store_req_t;

endpackage : mem_pkg

// File: store_lane_align.sv
`timescale 1ns/100ps

module store_lane_align (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  mem_pkg::store_req_t             store_req_i,
    output logic                            wr_en_o,
    output logic [mem_pkg::MEM_ADDR_W-1:0]  wr_index_o,
    output logic [3:0]                      wr_mask_o,
    output logic [31:0]                     wr_data_o,
    output logic                            done_o
);

    import mem_pkg::*;

    logic done_q;

    // The write happens on the same edge that samples the request.
    assign wr_en_o    = store_req_i.request;
    assign wr_index_o = store_req_i.address[MEM_ADDR_W-1:0];  // Wraps modulo MEM_BYTES.

    // Width decode into a byte mask starting at lane 0.
    always_comb begin
        case (store_req_i.width)
            BYTE:      wr_mask_o = 4'b0001;
            HALF_WORD: wr_mask_o = 4'b0011;
            WORD:      wr_mask_o = 4'b1111;
            default:   wr_mask_o = 4'b0000;  // Undefined code, nothing written.
        endcase
    end

    // Lane k carries data byte k; unused lanes are driven to zero.
    always_comb begin
        for (int k = 0; k < MEM_LANES; k++) begin
            if (wr_mask_o[k]) begin
                wr_data_o[8*k +: 8] = store_req_i.data[8*k +: 8];
            end else begin
                wr_data_o[8*k +: 8] = 8'h00;
            end
        end
    end

    // Done follows every store request by one cycle, even an empty one.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= store_req_i.request;
        end
    end

    assign done_o = done_q;

endmodule : store_lane_align

// File: byte_ram.sv
`timescale 1ns/100ps

module byte_ram (
    input  logic                            clk_i,
    input  logic                            wr_en_i,
    input  logic [mem_pkg::MEM_ADDR_W-1:0]  wr_index_i,
    input  logic [3:0]                      wr_mask_i,
    input  logic [31:0]                     wr_data_i,
    input  logic [mem_pkg::MEM_ADDR_W-1:0]  rd_a_index_i,
    output logic [31:0]                     rd_a_word_o,
    input  logic [mem_pkg::MEM_ADDR_W-1:0]  rd_b_index_i,
    output logic [31:0]                     rd_b_word_o
);

    import mem_pkg::*;

    logic [7:0] mem_q [MEM_BYTES];  // Byte storage.

    // Array starts cleared.
    initial begin
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem_q[i] = 8'h00;
        end
    end

    // Masked write of up to four bytes from the start index.
    // The index sum keeps MEM_ADDR_W bits, so it wraps past the top byte.
    always @(posedge clk_i) begin
        if (wr_en_i) begin
            for (int k = 0; k < MEM_LANES; k++) begin
                if (wr_mask_i[k]) begin
                    mem_q[wr_index_i + MEM_ADDR_W'(k)] <= wr_data_i[8*k +: 8];
                end
            end
        end
    end

    // Tap A, four bytes from rd_a_index_i upward, little-endian.
    always_comb begin
        for (int k = 0; k < MEM_LANES; k++) begin
            rd_a_word_o[8*k +: 8] = mem_q[rd_a_index_i + MEM_ADDR_W'(k)];
        end
    end

    // Tap B, same assembly for the second reader.
    always_comb begin
        for (int k = 0; k < MEM_LANES; k++) begin
            rd_b_word_o[8*k +: 8] = mem_q[rd_b_index_i + MEM_ADDR_W'(k)];
        end
    end

endmodule : byte_ram

// File: word_read_port.sv
`timescale 1ns/100ps

module word_read_port #(
    parameter int unsigned ALIGN_BITS = 2  // Low address bits cleared, 0 to 2.
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  mem_pkg::rd_req_t                req_i,
    output logic [mem_pkg::MEM_ADDR_W-1:0]  rd_index_o,
    input  logic [31:0]                     rd_word_i,
    output mem_pkg::rd_rsp_t                rsp_o
);

    import mem_pkg::*;

    logic [MEM_ADDR_W-1:0] align_mask;
    rd_rsp_t               rsp_q;

    // Ones above the alignment bits, zeros below.
    assign align_mask = ~((MEM_ADDR_W'(1) << ALIGN_BITS) - MEM_ADDR_W'(1));

    // Upper address bits beyond the array are dropped.
    assign rd_index_o = req_i.address[MEM_ADDR_W-1:0] & align_mask;

    // Word is sampled on the request edge, so a same-edge store is not seen.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_q <= '0;
        end else begin
            rsp_q.valid <= req_i.request;  // One-cycle valid pulse.
            rsp_q.data  <= rd_word_i;
        end
    end

    assign rsp_o = rsp_q;

endmodule : word_read_port

// File: system_memory.sv
`timescale 1ns/100ps

module system_memory (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    // Data channel
    input  mem_pkg::rd_req_t     load_req_i,
    output mem_pkg::rd_rsp_t     load_rsp_o,
    input  mem_pkg::store_req_t  store_req_i,
    output logic                 store_done_o,

    // Instruction channel
    input  mem_pkg::rd_req_t     fetch_req_i,
    input  logic                 invalidate_i,
    output mem_pkg::rd_rsp_t     fetch_rsp_o
);

    import mem_pkg::*;

    logic                  wr_en;
    logic [MEM_ADDR_W-1:0] wr_index;
    logic [3:0]            wr_mask;
    logic [31:0]           wr_data;

    logic [MEM_ADDR_W-1:0] load_index;
    logic [31:0]           load_word;
    logic [MEM_ADDR_W-1:0] fetch_index;
    logic [31:0]           fetch_word;
    rd_rsp_t               fetch_rsp;

    store_lane_align store_align (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .store_req_i (store_req_i),
        .wr_en_o     (wr_en),
        .wr_index_o  (wr_index),
        .wr_mask_o   (wr_mask),
        .wr_data_o   (wr_data),
        .done_o      (store_done_o)
    );

    byte_ram ram (
        .clk_i        (clk_i),
        .wr_en_i      (wr_en),
        .wr_index_i   (wr_index),
        .wr_mask_i    (wr_mask),
        .wr_data_i    (wr_data),
        .rd_a_index_i (load_index),
        .rd_a_word_o  (load_word),
        .rd_b_index_i (fetch_index),
        .rd_b_word_o  (fetch_word)
    );

    // Loads are word aligned.
    word_read_port #(
        .ALIGN_BITS (2)
    ) load_port (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (load_req_i),
        .rd_index_o (load_index),
        .rd_word_i  (load_word),
        .rsp_o      (load_rsp_o)
    );

    // Fetches are halfword aligned for compressed instructions.
    word_read_port #(
        .ALIGN_BITS (1)
    ) fetch_port (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (fetch_req_i),
        .rd_index_o (fetch_index),
        .rd_word_i  (fetch_word),
        .rsp_o      (fetch_rsp)
    );

    // Invalidate kills the fetch in its response cycle only.
    always_comb begin
        fetch_rsp_o.valid = fetch_rsp.valid & ~invalidate_i;
        fetch_rsp_o.data  = fetch_rsp.data;  // Data passes through unchanged.
    end

endmodule : system_memory

// File: system_memory_properties.sv
`timescale 1ns/100ps

module system_memory_properties (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input mem_pkg::rd_req_t     load_req_i,
    input mem_pkg::rd_rsp_t     load_rsp_o,
    input mem_pkg::store_req_t  store_req_i,
    input logic                 store_done_o,
    input mem_pkg::rd_req_t     fetch_req_i,
    input logic                 invalidate_i,
    input mem_pkg::rd_rsp_t     fetch_rsp_o
);

    import mem_pkg::*;

    int unsigned fail_count = 0;  // Failed assertions so far.

    // Synchronous reset clears every output register.
    reset_outputs_low: assert property (@(posedge clk_i)
        !rst_n_i |=> (!load_rsp_o.valid && !fetch_rsp_o.valid && !store_done_o &&
                      load_rsp_o.data == '0 && fetch_rsp_o.data == '0))
        else begin
            fail_count++;
            $error("Outputs not cleared by reset");
        end

    store_done_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        store_req_i.request |=> store_done_o)
        else begin
            fail_count++;
            $error("store_done_o missing one cycle after a store request");
        end

    store_done_only_after_store: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !store_req_i.request |=> !store_done_o)
        else begin
            fail_count++;
            $error("store_done_o high without a store request");
        end

    load_valid_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        load_req_i.request |=> load_rsp_o.valid)
        else begin
            fail_count++;
            $error("Load valid missing one cycle after a load request");
        end

    load_valid_only_after_load: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !load_req_i.request |=> !load_rsp_o.valid)
        else begin
            fail_count++;
            $error("Load valid high without a load request");
        end

    // Fetch valid follows a request unless invalidate kills it in the response cycle.
    fetch_valid_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fetch_req_i.request |=> (fetch_rsp_o.valid == !invalidate_i))
        else begin
            fail_count++;
            $error("Fetch valid not equal to NOT invalidate_i one cycle after a fetch request");
        end

    fetch_valid_needs_request: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !fetch_req_i.request |=> !fetch_rsp_o.valid)
        else begin
            fail_count++;
            $error("Fetch valid high without a fetch request");
        end

endmodule : system_memory_properties

bind system_memory system_memory_properties system_memory_props (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .load_req_i   (load_req_i),
    .load_rsp_o   (load_rsp_o),
    .store_req_i  (store_req_i),
    .store_done_o (store_done_o),
    .fetch_req_i  (fetch_req_i),
    .invalidate_i (invalidate_i),
    .fetch_rsp_o  (fetch_rsp_o)
);

// File: tb_system_memory.sv
`timescale 1ns/100ps

module tb_system_memory;

    import mem_pkg::*;

    logic       clk_i;
    logic       rst_n_i;
    rd_req_t    load_req_i;
    rd_rsp_t    load_rsp_o;
    store_req_t store_req_i;
    logic       store_done_o;
    rd_req_t    fetch_req_i;
    logic       invalidate_i;
    rd_rsp_t    fetch_rsp_o;

    int unsigned rsp_timeout = 8;  // Cycles allowed for any response.
    int unsigned ops_run     = 0;

    system_memory system_memory_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .load_req_i   (load_req_i),
        .load_rsp_o   (load_rsp_o),
        .store_req_i  (store_req_i),
        .store_done_o (store_done_o),
        .fetch_req_i  (fetch_req_i),
        .invalidate_i (invalidate_i),
        .fetch_rsp_o  (fetch_rsp_o)
    );

    initial begin
        clk_i = 1'b0;
    end

    always #5 clk_i = ~clk_i;  // 10 ns period.

    always @(negedge clk_i) begin
        if (system_memory_i.system_memory_props.fail_count != 0) begin
            abort_run("A bound assertion on system_memory failed");
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_rsp(input rd_rsp_t actual, input rd_rsp_t expected,
                             input string what);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %0t: %s got valid %b data %h, expected valid %b data %h",
                                $time, what, actual.valid, actual.data,
                                expected.valid, expected.data));
        end
    endtask

    task automatic check_done(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %0t: %s is %b, expected %b",
                                $time, what, actual, expected));
        end
    endtask

    task automatic check_latency(input int cycles, input string what);
        if (cycles != 1) begin
            abort_run($sformatf("FAIL %0t: %s came %0d cycles after the request, expected 1",
                                $time, what, cycles));
        end
    endtask

    task automatic wait_load_valid(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!load_rsp_o.valid && cycles < rsp_timeout);
        if (!load_rsp_o.valid) begin
            abort_run("Timed out waiting for a load response");
        end
    endtask

    task automatic wait_fetch_valid(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!fetch_rsp_o.valid && cycles < rsp_timeout);
        if (!fetch_rsp_o.valid) begin
            abort_run("Timed out waiting for a fetch response");
        end
    endtask

    task automatic wait_store_done(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
        end while (!store_done_o && cycles < rsp_timeout);
        if (!store_done_o) begin
            abort_run("Timed out waiting for a store to complete");
        end
    endtask

    task automatic do_store(input logic [1:0] width, input logic [31:0] addr,
                            input logic [31:0] data);
        store_req_t req;
        int         cycles;
        req.request = 1'b1;
        req.width   = store_width_e'(width);
        req.address = addr;
        req.data    = data;
        @(posedge clk_i);
        store_req_i <= req;
        @(posedge clk_i);
        store_req_i.request <= 1'b0;  // DUT samples the strobe on this edge.
        wait_store_done(cycles);
        check_latency(cycles, "store done");
        @(negedge clk_i);
        check_done(store_done_o, 1'b0, "store done one cycle later");
    endtask

    task automatic do_load(input logic [31:0] addr, input logic [31:0] exp_word);
        rd_req_t req;
        rd_rsp_t expected;
        int      cycles;
        req.request    = 1'b1;
        req.address    = addr;
        expected.valid = 1'b1;
        expected.data  = exp_word;
        @(posedge clk_i);
        load_req_i <= req;
        @(posedge clk_i);
        load_req_i.request <= 1'b0;
        wait_load_valid(cycles);
        check_latency(cycles, "load response");
        check_rsp(load_rsp_o, expected, $sformatf("load at %h", addr));
    endtask

    task automatic do_fetch(input logic [31:0] addr, input logic inv,
                            input logic exp_valid, input logic [31:0] exp_word);
        rd_req_t req;
        rd_rsp_t expected;
        int      cycles;
        req.request    = 1'b1;
        req.address    = addr;
        expected.valid = exp_valid;
        expected.data  = exp_word;
        @(posedge clk_i);
        fetch_req_i <= req;
        @(posedge clk_i);
        fetch_req_i.request <= 1'b0;
        invalidate_i        <= inv;  // Level covers the response cycle.
        if (inv) begin
            @(negedge clk_i);  // A killed fetch never shows valid.
        end else begin
            wait_fetch_valid(cycles);
            check_latency(cycles, "fetch response");
        end
        check_rsp(fetch_rsp_o, expected, $sformatf("fetch at %h inv %b", addr, inv));
        @(posedge clk_i);
        invalidate_i <= 1'b0;
    endtask

    // Load and store on one edge, then a second load on the next edge.
    task automatic do_load_store(input logic [1:0] width, input logic [31:0] addr,
                                 input logic [31:0] data, input logic [31:0] old_word,
                                 input logic [31:0] new_word);
        rd_req_t    lreq;
        store_req_t sreq;
        rd_rsp_t    expected;
        int         cycles;
        lreq.request   = 1'b1;
        lreq.address   = addr;
        sreq.request   = 1'b1;
        sreq.width     = store_width_e'(width);
        sreq.address   = addr;
        sreq.data      = data;
        expected.valid = 1'b1;
        @(posedge clk_i);
        load_req_i  <= lreq;
        store_req_i <= sreq;
        @(posedge clk_i);
        store_req_i.request <= 1'b0;  // The load strobe stays up for one more edge.
        wait_load_valid(cycles);
        check_latency(cycles, "same-edge load response");
        expected.data = old_word;
        check_rsp(load_rsp_o, expected, $sformatf("same-edge load at %h", addr));
        check_done(store_done_o, 1'b1, "same-edge store done");
        @(posedge clk_i);
        load_req_i.request <= 1'b0;
        wait_load_valid(cycles);
        check_latency(cycles, "next-edge load response");
        expected.data = new_word;
        check_rsp(load_rsp_o, expected, $sformatf("next-edge load at %h", addr));
    endtask

    task automatic expect_fields(input int got, input int wanted, input logic [7:0] tag);
        if (got != wanted) begin
            abort_run($sformatf("Vector line %c has %0d fields instead of %0d",
                                tag, got, wanted));
        end
    endtask

    task automatic replay_vectors(input int fd);
        logic [7:0]    tag;
        logic [31:0]   f0, f1, f2, f3, f4;
        logic [1023:0] line_buf;
        int            n;
        while ($fscanf(fd, " %c", tag) == 1) begin
            case (tag)
                "#": n = $fgets(line_buf, fd);  // Skip the rest of a comment line.
                "S": begin
                    n = $fscanf(fd, "%h %h %h", f0, f1, f2);
                    expect_fields(n, 3, tag);
                    do_store(f0[1:0], f1, f2);
                end
                "L": begin
                    n = $fscanf(fd, "%h %h", f0, f1);
                    expect_fields(n, 2, tag);
                    do_load(f0, f1);
                end
                "F": begin
                    n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                    expect_fields(n, 4, tag);
                    do_fetch(f0, f1[0], f2[0], f3);
                end
                "B": begin
                    n = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
                    expect_fields(n, 5, tag);
                    do_load_store(f0[1:0], f1, f2, f3, f4);
                end
                default: abort_run($sformatf("Unknown vector tag %c in the vector file", tag));
            endcase
            if (tag != "#") begin
                ops_run++;
                repeat ($urandom % 4) @(posedge clk_i);  // Zero to three idle cycles.
            end
        end
    endtask

    initial begin
        int      fd;
        rd_rsp_t zero_rsp;
        zero_rsp = '0;
        void'($urandom(32'hd61));
        rst_n_i      <= 1'b0;
        load_req_i   <= '0;
        store_req_i  <= '0;
        fetch_req_i  <= '0;
        invalidate_i <= 1'b0;
        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_rsp(load_rsp_o, zero_rsp, "load response after reset");
        check_rsp(fetch_rsp_o, zero_rsp, "fetch response after reset");
        check_done(store_done_o, 1'b0, "store done after reset");

        fd = $fopen("system_memory_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the vector file system_memory_vectors.txt");
        end else begin
            replay_vectors(fd);
            $fclose(fd);
            if (ops_run == 0) begin
                abort_run("The vector file held no vectors");
            end else if (system_memory_i.system_memory_props.fail_count != 0) begin
                abort_run("A bound assertion on system_memory failed");
            end else begin
                $display("All tests passed!");
                $finish;
            end
        end
    end

endmodule : tb_system_memory

// File: system_memory_vectors.txt
# S width addr data | L addr word | F addr inv valid word | B width addr data old new
# Width 0 byte, 1 halfword, 2 word, 3 undefined. All fields hex.
# Empty memory reads zero
L 00000000 00000000
L 0000007c 00000000
F 00000042 0 1 00000000
# Little-endian merge inside one word
S 2 00000010 11223344
S 0 00000011 000000aa
S 1 00000012 0000bbcc
L 00000010 bbccaa44
S 0 00000013 ffffff5a
L 00000010 5accaa44
# Load alignment and dropped upper bits
L 00000013 5accaa44
L 00000011 5accaa44
L 00000012 5accaa44
L 00000110 5accaa44
# Halfword fetch crosses into the next word
S 2 00000014 d4c3b2a1
F 00000012 0 1 b2a15acc
F 00000013 0 1 b2a15acc
F 00000016 0 1 0000d4c3
F 00000010 0 1 5accaa44
# Fetch at the top of memory wraps to byte 0
S 2 000000fc 87654321
S 1 00000000 00009a78
F 000000fe 0 1 9a788765
F 000001ff 0 1 9a788765
F 800000fe 0 1 9a788765
L 000000fc 87654321
L 00000000 00009a78
# Invalidate kills the valid, a repeat returns the word
F 00000014 1 0 d4c3b2a1
F 00000014 0 1 d4c3b2a1
# Stores crossing the end of memory
S 2 000000fe 0f0e0d0c
L 000000fc 0d0c4321
L 00000000 00000f0e
S 1 000001ff 0000bead
L 000000fc ad0c4321
L 00000000 00000fbe
F 000000fe 0 1 0fbead0c
# Undefined width writes nothing
S 3 00000020 ffffffff
L 00000020 00000000
# Same-edge load sees old data, next edge sees new
B 2 00000030 cafef00d 00000000 cafef00d
B 0 00000031 00000077 cafef00d cafe770d
L 00000033 cafe770d
B 1 000000ff 00001234 ad0c4321 340c4321
L 00000000 00000f12

// File: filelist.f
mem_pkg.sv
store_lane_align.sv
byte_ram.sv
word_read_port.sv
system_memory.sv
system_memory_properties.sv
tb_system_memory.sv
